/* hdl/dsa_types_pkg.sv */
package dsa_types_pkg;

    // ------------------------------
    // operand widths
    // ------------------------------

    // all group elements fit in one word
    localparam int OPERAND_W = 32;

    // one element of the additive group mod q
    typedef logic [OPERAND_W-1:0] operand_t;

    // full product of two operands, used by reference models
    typedef logic [2*OPERAND_W-1:0] product_t;

    // ------------------------------
    // default group constants
    // ------------------------------

    // largest prime below 2^32
    localparam operand_t DEFAULT_Q_ORDER = 32'd4294967291;

    // generator of the toy group, any nonzero value below q works
    localparam operand_t DEFAULT_G_BASE = 32'h1234_5679;

endpackage

/* hdl/dsa_uop_pkg.sv */
package dsa_uop_pkg;

    // host commands
    typedef enum logic [1:0] {
        NONE   = 2'd0,
        KEYGEN = 2'd1,
        SIGN   = 2'd2
    } cmd_e;

    // ------------------------------
    // microcode
    // ------------------------------
    typedef enum logic [2:0] {
        NOP     = 3'd0,
        WR_CORE = 3'd1,
        RD_CORE = 3'd2,
        MOD_ADD = 3'd3,
        MOD_SUB = 3'd4,
        MOD_MUL = 3'd5,
        END     = 3'd6
    } uop_e;

    // source of a WR_CORE or target of a RD_CORE
    typedef enum logic [2:0] {
        PRIV_ID = 3'd0,
        MSG_ID  = 3'd1,
        R_ID    = 3'd2,
        MASK_ID = 3'd3,
        G_ID    = 3'd4,
        PUB_ID  = 3'd5,
        S_ID    = 3'd6
    } reg_id_e;

    typedef logic [2:0] mem_addr_t;
    typedef logic [5:0] prog_addr_t;

    typedef struct packed {
        uop_e      opcode;
        reg_id_e   reg_id;
        mem_addr_t dst;
        mem_addr_t src_a;
        mem_addr_t src_b;
    } instr_t;

    // program entry points, address 0 holds NOP
    localparam prog_addr_t IDLE_ADDR    = 6'd0;
    localparam prog_addr_t KEYGEN_START = 6'd1;
    localparam prog_addr_t SIGN_START   = 6'd8;

endpackage

/* hdl/arith_bus_if.sv */
`timescale 1ns/1ps

interface arith_bus_if;
    import dsa_uop_pkg::*;

    // current micro-instruction, valid while issue is high
    instr_t instr;
    logic   issue;
    // high while a multiply is running
    logic   busy;

    modport seq_mp (
        output instr,
        output issue,
        input  busy
    );

    modport unit_mp (
        input  instr,
        input  issue,
        output busy
    );

    modport obs_mp (
        input instr,
        input issue
    );

endinterface

/* hdl/dsa_program_rom.sv */
`timescale 1ns/1ps

module dsa_program_rom (
    input  logic                    clk,
    input  logic                    reset_n,
    input  dsa_uop_pkg::prog_addr_t addr_i,
    output dsa_uop_pkg::instr_t     instr_o
);
    import dsa_uop_pkg::*;

    instr_t instr_d;

    function automatic instr_t uop(uop_e op, reg_id_e id, mem_addr_t dst,
                                   mem_addr_t a, mem_addr_t b);
        return '{opcode: op, reg_id: id, dst: dst, src_a: a, src_b: b};
    endfunction

    always_comb begin
        case (addr_i)
            IDLE_ADDR:           instr_d = uop(NOP, PRIV_ID, 3'd0, 3'd0, 3'd0);
            // keygen: pub = priv * G
            KEYGEN_START:        instr_d = uop(WR_CORE, PRIV_ID, 3'd0, 3'd0, 3'd0);
            KEYGEN_START + 6'd1: instr_d = uop(WR_CORE, G_ID, 3'd1, 3'd0, 3'd0);
            KEYGEN_START + 6'd2: instr_d = uop(MOD_MUL, PRIV_ID, 3'd2, 3'd0, 3'd1);
            KEYGEN_START + 6'd3: instr_d = uop(RD_CORE, PUB_ID, 3'd0, 3'd2, 3'd0);
            KEYGEN_START + 6'd4: instr_d = uop(END, PRIV_ID, 3'd0, 3'd0, 3'd0);
            // sign: m0 = h, m1 = priv, m2 = r, m3 = d
            SIGN_START:          instr_d = uop(WR_CORE, MSG_ID, 3'd0, 3'd0, 3'd0);
            SIGN_START + 6'd1:   instr_d = uop(WR_CORE, PRIV_ID, 3'd1, 3'd0, 3'd0);
            SIGN_START + 6'd2:   instr_d = uop(WR_CORE, R_ID, 3'd2, 3'd0, 3'd0);
            SIGN_START + 6'd3:   instr_d = uop(WR_CORE, MASK_ID, 3'd3, 3'd0, 3'd0);
            // first half: (priv - d) * r + (h - d)
            SIGN_START + 6'd4:   instr_d = uop(MOD_SUB, PRIV_ID, 3'd4, 3'd1, 3'd3);
            SIGN_START + 6'd5:   instr_d = uop(MOD_MUL, PRIV_ID, 3'd4, 3'd4, 3'd2);
            SIGN_START + 6'd6:   instr_d = uop(MOD_SUB, PRIV_ID, 3'd5, 3'd0, 3'd3);
            SIGN_START + 6'd7:   instr_d = uop(MOD_ADD, PRIV_ID, 3'd4, 3'd4, 3'd5);
            // second half: d * r + d
            SIGN_START + 6'd8:   instr_d = uop(MOD_MUL, PRIV_ID, 3'd5, 3'd3, 3'd2);
            SIGN_START + 6'd9:   instr_d = uop(MOD_ADD, PRIV_ID, 3'd5, 3'd5, 3'd3);
            // the mask cancels in the sum
            SIGN_START + 6'd10:  instr_d = uop(MOD_ADD, PRIV_ID, 3'd6, 3'd4, 3'd5);
            SIGN_START + 6'd11:  instr_d = uop(RD_CORE, S_ID, 3'd0, 3'd6, 3'd0);
            SIGN_START + 6'd12:  instr_d = uop(END, PRIV_ID, 3'd0, 3'd0, 3'd0);
            default:             instr_d = uop(NOP, PRIV_ID, 3'd0, 3'd0, 3'd0);
        endcase
    end

    // registered output, one cycle from address to instruction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_o <= uop(NOP, PRIV_ID, 3'd0, 3'd0, 3'd0);
        end else begin
            instr_o <= instr_d;
        end
    end

endmodule

/* hdl/mod_arith_unit.sv */
`timescale 1ns/1ps

module mod_arith_unit #(
    parameter dsa_types_pkg::operand_t Q_ORDER = dsa_types_pkg::DEFAULT_Q_ORDER
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    arith_bus_if.unit_mp            bus,
    input  dsa_types_pkg::operand_t wr_data_i,
    output dsa_types_pkg::operand_t rd_data_o
);
    import dsa_types_pkg::*;
    import dsa_uop_pkg::*;

    localparam int CNT_W = $clog2(OPERAND_W);

    operand_t         mem [8];
    operand_t         mul_a;
    operand_t         mul_b;
    operand_t         acc;
    operand_t         acc_next;
    mem_addr_t        mul_dst;
    logic [CNT_W-1:0] step_cnt;
    logic             busy;
    logic             mem_in_range;

    // inputs are already below q, so one subtraction is enough
    function automatic operand_t add_mod(operand_t a, operand_t b);
        logic [OPERAND_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, Q_ORDER}) begin
            sum = sum - {1'b0, Q_ORDER};
        end
        return sum[OPERAND_W-1:0];
    endfunction

    function automatic operand_t sub_mod(operand_t a, operand_t b);
        return (a >= b) ? a - b : a - b + Q_ORDER;
    endfunction

    assign rd_data_o = mem[bus.instr.src_a];
    assign bus.busy  = busy;

    // ------------------------------
    // serial multiplier, msb first double and add
    // ------------------------------
    always_comb begin
        acc_next = add_mod(acc, acc);
        if (mul_b[OPERAND_W-1]) begin
            acc_next = add_mod(acc_next, mul_a);
        end
    end

    // multiplier operands are cleared along with the memory
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mul_a   <= '0;
            mul_b   <= '0;
            mul_dst <= '0;
            acc     <= '0;
        end else if (zeroize_i) begin
            mul_a   <= '0;
            mul_b   <= '0;
            mul_dst <= '0;
            acc     <= '0;
        end else if (busy) begin
            acc   <= acc_next;
            mul_b <= mul_b << 1;
        end else if (bus.issue && bus.instr.opcode == MOD_MUL) begin
            mul_a   <= mem[bus.instr.src_a];
            mul_b   <= mem[bus.instr.src_b];
            mul_dst <= bus.instr.dst;
            acc     <= '0;
        end
    end

    // operand memory and busy flag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 8; i++) mem[i] <= '0;
            busy     <= 1'b0;
            step_cnt <= '0;
        end else if (zeroize_i) begin
            for (int i = 0; i < 8; i++) mem[i] <= '0;
            busy     <= 1'b0;
            step_cnt <= '0;
        end else if (busy) begin
            step_cnt <= step_cnt + 1'b1;
            if (step_cnt == CNT_W'(OPERAND_W - 1)) begin
                busy         <= 1'b0;
                mem[mul_dst] <= acc_next;
            end
        end else if (bus.issue) begin
            case (bus.instr.opcode)
                WR_CORE: mem[bus.instr.dst] <= wr_data_i;
                MOD_ADD: mem[bus.instr.dst] <= add_mod(mem[bus.instr.src_a], mem[bus.instr.src_b]);
                MOD_SUB: mem[bus.instr.dst] <= sub_mod(mem[bus.instr.src_a], mem[bus.instr.src_b]);
                MOD_MUL: begin
                    busy     <= 1'b1;
                    step_cnt <= '0;
                end
                default: ;
            endcase
        end
    end

    // write data from the operand block must arrive reduced
    always_comb begin
        mem_in_range = 1'b1;
        for (int i = 0; i < 8; i++) begin
            if (mem[i] >= Q_ORDER) mem_in_range = 1'b0;
        end
    end

    a_mem_reduced: assert property (@(posedge clk) disable iff (!reset_n) mem_in_range)
        else $error("operand memory holds a word not below q");

endmodule

/* hdl/operand_regs.sv */
`timescale 1ns/1ps

module operand_regs #(
    parameter dsa_types_pkg::operand_t Q_ORDER = dsa_types_pkg::DEFAULT_Q_ORDER,
    parameter dsa_types_pkg::operand_t G_BASE  = dsa_types_pkg::DEFAULT_G_BASE
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  logic                    start_i,
    arith_bus_if.obs_mp             bus,
    input  dsa_uop_pkg::cmd_e       active_cmd_i,
    input  dsa_types_pkg::operand_t priv_i,
    input  dsa_types_pkg::operand_t msg_i,
    input  dsa_types_pkg::operand_t r_i,
    input  dsa_types_pkg::operand_t mask_i,
    input  dsa_types_pkg::operand_t rd_data_i,
    output dsa_types_pkg::operand_t wr_data_o,
    output logic                    range_err_o,
    output dsa_types_pkg::operand_t pub_o,
    output dsa_types_pkg::operand_t sig_s_o
);
    import dsa_types_pkg::*;
    import dsa_uop_pkg::*;

    operand_t priv_q;
    operand_t msg_q;
    operand_t r_q;
    operand_t mask_q;
    logic     capture;
    logic     rd_capture;
    logic     priv_bad;
    logic     r_bad;

    // any 32-bit value is below 2q, one step reduces it
    function automatic operand_t reduce_once(operand_t v);
        return (v >= Q_ORDER) ? v - Q_ORDER : v;
    endfunction

    // active command is NONE only while the sequencer idles
    assign capture    = start_i && (active_cmd_i == NONE);
    assign rd_capture = bus.issue && (bus.instr.opcode == RD_CORE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            {priv_q, msg_q, r_q, mask_q} <= '0;
            {pub_o, sig_s_o}             <= '0;
        end else if (zeroize_i) begin
            {priv_q, msg_q, r_q, mask_q} <= '0;
            {pub_o, sig_s_o}             <= '0;
        end else begin
            if (capture) begin
                priv_q <= priv_i;
                msg_q  <= reduce_once(msg_i);
                r_q    <= r_i;
                mask_q <= reduce_once(mask_i);
            end
            if (rd_capture && bus.instr.reg_id == PUB_ID) pub_o <= rd_data_i;
            if (rd_capture && bus.instr.reg_id == S_ID) sig_s_o <= rd_data_i;
        end
    end

    // ------------------------------
    // write data towards the unit
    // ------------------------------
    always_comb begin
        case (bus.instr.reg_id)
            PRIV_ID: wr_data_o = priv_q;
            MSG_ID:  wr_data_o = msg_q;
            R_ID:    wr_data_o = r_q;
            MASK_ID: wr_data_o = mask_q;
            G_ID:    wr_data_o = G_BASE;
            default: wr_data_o = '0;
        endcase
    end

    // range checks, r only matters when signing
    assign priv_bad    = (priv_q == '0) || (priv_q >= Q_ORDER);
    assign r_bad       = (r_q == '0) || (r_q >= Q_ORDER);
    assign range_err_o = ((active_cmd_i != NONE) && priv_bad) ||
                         ((active_cmd_i == SIGN) && r_bad);

endmodule

/* hdl/dsa_sequencer_ctrl.sv */
`timescale 1ns/1ps

module dsa_sequencer_ctrl (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  logic                    start_i,
    input  dsa_uop_pkg::cmd_e       cmd_i,
    input  logic                    range_err_i,
    input  dsa_uop_pkg::instr_t     instr_i,
    arith_bus_if.seq_mp             bus,
    output dsa_uop_pkg::prog_addr_t addr_o,
    output dsa_uop_pkg::cmd_e       active_cmd_o,
    output logic                    ready_o,
    output logic                    valid_o,
    output logic                    done_o,
    output logic                    error_o
);
    import dsa_uop_pkg::*;

    typedef enum logic [1:0] {IDLE, FETCH, ISSUE, WAIT} state_e;

    state_e     state;
    prog_addr_t pc;
    logic       accept;

    assign accept    = (state == IDLE) && start_i && (cmd_i == KEYGEN || cmd_i == SIGN);
    assign addr_o    = pc;
    assign ready_o   = (state == IDLE);
    assign bus.instr = instr_i;
    assign bus.issue = (state == ISSUE);

    // ------------------------------
    // control FSM
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= IDLE;
            pc           <= IDLE_ADDR;
            active_cmd_o <= NONE;
            {valid_o, done_o, error_o} <= 3'b000;
        end else if (zeroize_i) begin
            state        <= IDLE;
            pc           <= IDLE_ADDR;
            active_cmd_o <= NONE;
            {valid_o, done_o, error_o} <= 3'b000;
        end else begin
            done_o  <= 1'b0;
            error_o <= 1'b0;
            case (state)
                IDLE: if (accept) begin
                    pc           <= (cmd_i == SIGN) ? SIGN_START : KEYGEN_START;
                    active_cmd_o <= cmd_i;
                    valid_o      <= 1'b0;
                    state        <= FETCH;
                end
                // inputs were captured on the accept edge, check them once here
                FETCH: if (range_err_i) begin
                    pc           <= IDLE_ADDR;
                    active_cmd_o <= NONE;
                    error_o      <= 1'b1;
                    state        <= IDLE;
                end else begin
                    state <= ISSUE;
                end
                ISSUE: if (instr_i.opcode == END) begin
                    pc           <= IDLE_ADDR;
                    active_cmd_o <= NONE;
                    done_o       <= 1'b1;
                    valid_o      <= 1'b1;
                    state        <= IDLE;
                end else begin
                    pc    <= pc + 6'd1;
                    state <= WAIT;
                end
                // rom fetches the next word here, stall while a multiply runs
                WAIT: if (!bus.busy) state <= ISSUE;
                default: state <= IDLE;
            endcase
        end
    end

    a_done_error_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(done_o && error_o)) else $error("done and error high together");

    a_no_issue_busy: assert property (@(posedge clk) disable iff (!reset_n)
        !(bus.issue && bus.busy)) else $error("instruction issued while unit busy");

endmodule

/* hdl/dsa_core_top.sv */
`timescale 1ns/1ps

module dsa_core_top #(
    parameter dsa_types_pkg::operand_t Q_ORDER = dsa_types_pkg::DEFAULT_Q_ORDER,
    parameter dsa_types_pkg::operand_t G_BASE  = dsa_types_pkg::DEFAULT_G_BASE
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  logic                    start_i,
    input  dsa_uop_pkg::cmd_e       cmd_i,
    input  dsa_types_pkg::operand_t priv_i,
    input  dsa_types_pkg::operand_t msg_i,
    input  dsa_types_pkg::operand_t r_i,
    input  dsa_types_pkg::operand_t mask_i,
    output logic                    ready_o,
    output logic                    valid_o,
    output logic                    done_o,
    output logic                    error_o,
    output dsa_types_pkg::operand_t pub_o,
    output dsa_types_pkg::operand_t sig_s_o
);
    import dsa_types_pkg::*;
    import dsa_uop_pkg::*;

    prog_addr_t prog_addr;
    instr_t     prog_instr;
    cmd_e       active_cmd;
    operand_t   wr_data;
    operand_t   rd_data;
    logic       range_err;

    arith_bus_if arith_bus ();

    dsa_sequencer_ctrl dsa_sequencer_ctrl_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .start_i      (start_i),
        .cmd_i        (cmd_i),
        .range_err_i  (range_err),
        .instr_i      (prog_instr),
        .bus          (arith_bus.seq_mp),
        .addr_o       (prog_addr),
        .active_cmd_o (active_cmd),
        .ready_o      (ready_o),
        .valid_o      (valid_o),
        .done_o       (done_o),
        .error_o      (error_o)
    );

    dsa_program_rom dsa_program_rom_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .addr_i  (prog_addr),
        .instr_o (prog_instr)
    );

    mod_arith_unit #(
        .Q_ORDER (Q_ORDER)
    ) mod_arith_unit_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .bus       (arith_bus.unit_mp),
        .wr_data_i (wr_data),
        .rd_data_o (rd_data)
    );

    operand_regs #(
        .Q_ORDER (Q_ORDER),
        .G_BASE  (G_BASE)
    ) operand_regs_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .start_i      (start_i),
        .bus          (arith_bus.obs_mp),
        .active_cmd_i (active_cmd),
        .priv_i       (priv_i),
        .msg_i        (msg_i),
        .r_i          (r_i),
        .mask_i       (mask_i),
        .rd_data_i    (rd_data),
        .wr_data_o    (wr_data),
        .range_err_o  (range_err),
        .pub_o        (pub_o),
        .sig_s_o      (sig_s_o)
    );

endmodule

/* test/tb_dsa_core.sv */
`timescale 1ns/1ps

module tb_dsa_core;
    import dsa_types_pkg::*;
    import dsa_uop_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 6;
    // longest wait for one command, 40 multiplies of 40 cycles
    localparam int MAX_WAIT   = 40 * 40;
    localparam operand_t Q    = DEFAULT_Q_ORDER;

    logic     clk;
    logic     reset_n;
    logic     zeroize_i;
    logic     start_i;
    cmd_e     cmd_i;
    operand_t priv_i;
    operand_t msg_i;
    operand_t r_i;
    operand_t mask_i;
    logic     ready_o;
    logic     valid_o;
    logic     done_o;
    logic     error_o;
    operand_t pub_o;
    operand_t sig_s_o;

    // expected results and check windows
    cmd_e     exp_cmd;
    operand_t exp_pub;
    operand_t exp_sig;
    logic     expect_error;
    logic     zero_check;
    logic     busy_probe;
    int       err_count;
    int       tests_failed;
    int       test_err_base;

    dsa_core_top #(
        .Q_ORDER (DEFAULT_Q_ORDER),
        .G_BASE  (DEFAULT_G_BASE)
    ) dsa_core_top_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .start_i   (start_i),
        .cmd_i     (cmd_i),
        .priv_i    (priv_i),
        .msg_i     (msg_i),
        .r_i       (r_i),
        .mask_i    (mask_i),
        .ready_o   (ready_o),
        .valid_o   (valid_o),
        .done_o    (done_o),
        .error_o   (error_o),
        .pub_o     (pub_o),
        .sig_s_o   (sig_s_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic operand_t expected_pub(operand_t priv);
        product_t prod;
        prod = product_t'(priv) * product_t'(DEFAULT_G_BASE);
        return operand_t'(prod % product_t'(Q));
    endfunction

    // h is the message after one subtraction of q
    function automatic operand_t expected_sig(operand_t priv, operand_t msg, operand_t r);
        product_t h;
        product_t pr;
        h  = (msg >= Q) ? product_t'(msg - Q) : product_t'(msg);
        pr = (product_t'(priv) * product_t'(r)) % product_t'(Q);
        return operand_t'((h + pr) % product_t'(Q));
    endfunction

    function automatic operand_t random_in_range();
        operand_t v;
        v = $urandom;
        while (v == '0 || v >= Q) v = $urandom;
        return v;
    endfunction

    task automatic report_mismatch(string name, operand_t exp, operand_t act);
        $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
        err_count++;
    endtask

    task automatic report_problem(string what);
        $display("error at %0t: %s", $time, what);
        err_count++;
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic set_expect(cmd_e cmd, operand_t priv, operand_t msg, operand_t r, logic err);
        exp_cmd      = cmd;
        expect_error = err;
        exp_pub      = expected_pub(priv);
        exp_sig      = expected_sig(priv, msg, r);
    endtask

    // called on a falling edge, holds start for one cycle
    task automatic issue_start(cmd_e cmd, operand_t priv, operand_t msg, operand_t r,
                               operand_t mask);
        start_i = 1'b1;
        cmd_i   = cmd;
        priv_i  = priv;
        msg_i   = msg;
        r_i     = r;
        mask_i  = mask;
        @(negedge clk);
        start_i = 1'b0;
        cmd_i   = NONE;
    endtask

    task automatic wait_for_end();
        int cycles;
        cycles = 0;
        while (!(done_o || error_o) && cycles < MAX_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= MAX_WAIT) report_problem("no done_o or error_o before timeout");
        // let the checks on the strobe cycle run
        @(negedge clk);
    endtask

    task automatic run_cmd(cmd_e cmd, operand_t priv, operand_t msg, operand_t r,
                           operand_t mask, logic err);
        set_expect(cmd, priv, msg, r, err);
        issue_start(cmd, priv, msg, r, mask);
        wait_for_end();
    endtask

    task automatic finish_test(int num, string name);
        if (err_count == test_err_base) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: failed", num, name);
            tests_failed++;
        end
        test_err_base = err_count;
    endtask

    // ------------------------------
    // checks
    // ------------------------------
    a_pub_value: assert property (@(posedge clk) disable iff (!reset_n)
        done_o && exp_cmd == KEYGEN |-> pub_o == exp_pub)
        else report_mismatch("pub_o", exp_pub, $sampled(pub_o));

    a_sig_value: assert property (@(posedge clk) disable iff (!reset_n)
        done_o && exp_cmd == SIGN |-> sig_s_o == exp_sig)
        else report_mismatch("sig_s_o", exp_sig, $sampled(sig_s_o));

    // valid and ready both rise with done
    a_done_flags: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> valid_o && ready_o)
        else report_mismatch("valid_o,ready_o", 32'd3,
                             operand_t'({$sampled(valid_o), $sampled(ready_o)}));

    a_done_expected: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> !expect_error)
        else report_problem("done_o pulsed where a range error was expected");

    a_error_expected: assert property (@(posedge clk) disable iff (!reset_n)
        error_o |-> expect_error)
        else report_problem("error_o pulsed for inputs in range");

    a_error_flags: assert property (@(posedge clk) disable iff (!reset_n)
        error_o |-> !valid_o && ready_o)
        else report_mismatch("valid_o,ready_o", 32'd1,
                             operand_t'({$sampled(valid_o), $sampled(ready_o)}));

    a_reset_flags: assert property (@(posedge clk) disable iff (!reset_n)
        zero_check |-> {ready_o, valid_o, done_o, error_o} == 4'b1000)
        else report_mismatch("ready_o,valid_o,done_o,error_o", 32'h8,
            operand_t'({$sampled(ready_o), $sampled(valid_o),
                        $sampled(done_o), $sampled(error_o)}));

    a_reset_pub: assert property (@(posedge clk) disable iff (!reset_n)
        zero_check |-> pub_o == '0)
        else report_mismatch("pub_o", '0, $sampled(pub_o));

    a_reset_sig: assert property (@(posedge clk) disable iff (!reset_n)
        zero_check |-> sig_s_o == '0)
        else report_mismatch("sig_s_o", '0, $sampled(sig_s_o));

    a_busy_not_ready: assert property (@(posedge clk) disable iff (!reset_n)
        busy_probe |-> !ready_o)
        else report_problem("second start arrived while the controller was idle");

    initial begin
        #(NUM_TESTS * MAX_WAIT * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        operand_t priv;
        operand_t msg;
        operand_t r;
        operand_t d;
        void'($urandom(11));
        reset_n       = 1'b0;
        zeroize_i     = 1'b0;
        start_i       = 1'b0;
        cmd_i         = NONE;
        priv_i        = '0;
        msg_i         = '0;
        r_i           = '0;
        mask_i        = '0;
        exp_cmd       = NONE;
        exp_pub       = '0;
        exp_sig       = '0;
        expect_error  = 1'b0;
        zero_check    = 1'b0;
        busy_probe    = 1'b0;
        err_count     = 0;
        tests_failed  = 0;
        test_err_base = 0;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;

        zero_check = 1'b1;
        repeat (2) @(negedge clk);
        zero_check = 1'b0;
        finish_test(1, "reset state");

        repeat (4) begin
            run_cmd(KEYGEN, random_in_range(), $urandom, $urandom, $urandom, 1'b0);
        end
        finish_test(2, "keygen");

        // the same signature must come out under both masks
        priv = random_in_range();
        msg  = $urandom;
        r    = random_in_range();
        d    = $urandom;
        run_cmd(SIGN, priv, msg, r, d, 1'b0);
        run_cmd(SIGN, priv, msg, r, d ^ 32'h5a5a_0001, 1'b0);
        finish_test(3, "sign with two masks");

        run_cmd(SIGN, random_in_range(), Q, random_in_range(), $urandom, 1'b0);
        run_cmd(SIGN, random_in_range(), 32'hffff_ffff, random_in_range(), $urandom, 1'b0);
        finish_test(4, "message reduction");

        run_cmd(KEYGEN, '0, $urandom, $urandom, $urandom, 1'b1);
        run_cmd(SIGN, Q, $urandom, random_in_range(), $urandom, 1'b1);
        run_cmd(KEYGEN, 32'hffff_ffff, $urandom, $urandom, $urandom, 1'b1);
        run_cmd(SIGN, random_in_range(), $urandom, '0, $urandom, 1'b1);
        finish_test(5, "range errors");

        // a second start in the cycle after the accept must leave the first run intact
        priv = random_in_range();
        set_expect(KEYGEN, priv, '0, '0, 1'b0);
        issue_start(KEYGEN, priv, $urandom, $urandom, $urandom);
        busy_probe = 1'b1;
        issue_start(SIGN, priv ^ 32'h0000_0f0f, $urandom, random_in_range(), $urandom);
        busy_probe = 1'b0;
        wait_for_end();

        issue_start(SIGN, random_in_range(), $urandom, random_in_range(), $urandom);
        repeat (10) @(negedge clk);
        zeroize_i = 1'b1;
        @(negedge clk);
        zeroize_i  = 1'b0;
        zero_check = 1'b1;
        repeat (2) @(negedge clk);
        zero_check = 1'b0;
        finish_test(6, "ignored start and zeroize");

        $display("tests: %0d  failed tests: %0d  check failures: %0d",
                 NUM_TESTS, tests_failed, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/dsa_types_pkg.sv
hdl/dsa_uop_pkg.sv
hdl/arith_bus_if.sv
hdl/dsa_program_rom.sv
hdl/mod_arith_unit.sv
hdl/operand_regs.sv
hdl/dsa_sequencer_ctrl.sv
hdl/dsa_core_top.sv
test/tb_dsa_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass is decided by the printed result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dsa_core -f sources.f \
    && ./obj_dir/Vtb_dsa_core | tee /dev/stderr | grep -qF "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
